// ==== logic/sdramGeomPkg.sv ====
//********************
// Array geometry of the four-bank SDRAM model
// Each bank holds 64 rows of 256 columns; row address bits above
// RowBits are not stored
//********************
package sdramGeomPkg;

    //********************
    // Widths and counts
    //********************
    localparam int AddrBits = 11;
    localparam int BankBits = 2;
    localparam int NumBanks = 4;
    localparam int RowBits  = 6;
    localparam int ColBits  = 8;
    localparam int DataBits = 32;
    localparam int MaskBits = 4;

    //********************
    // Bus and address types
    //********************
    typedef logic [AddrBits-1:0] addrT;
    typedef logic [BankBits-1:0] bankT;
    typedef logic [RowBits-1:0]  rowT;
    typedef logic [ColBits-1:0]  colT;

    // One DQ word and its byte lanes
    typedef logic [DataBits-1:0] dataT;
    typedef logic [MaskBits-1:0] maskT;

    // Read access as it travels down the CAS latency pipeline
    typedef struct packed {
        bankT bank;
        rowT  row;
        colT  col;
    } readAccessT;

endpackage

// ==== logic/sdramCmdPkg.sv ====
//********************
// Command codes and mode register layout
// Only BL 1/2/4/8 and CL 2/3 are modelled
// Refresh and burst terminate decode as NOP
//********************
package sdramCmdPkg;

    //********************
    // Decoded command
    //********************
    typedef enum logic [2:0] {
        Nop       = 3'd0,
        Active    = 3'd1,
        Read      = 3'd2,
        Write     = 3'd3,
        Precharge = 3'd4,
        LoadMode  = 3'd5
    } cmdT;

    //********************
    // Mode register fields
    //********************
    // Codes follow the A2..A0 burst length field
    typedef enum logic [2:0] {
        BurstLen1 = 3'b000,
        BurstLen2 = 3'b001,
        BurstLen4 = 3'b010,
        BurstLen8 = 3'b011
    } burstLenT;

    // Codes follow the A6..A4 latency field
    typedef enum logic [2:0] {
        CasLat2 = 3'b010,
        CasLat3 = 3'b011
    } casLatT;

    // Address bit positions
    localparam int AllBanksBit  = 10;
    localparam int BurstLenLsb  = 0;
    localparam int BurstTypeBit = 3;
    localparam int CasLatLsb    = 4;

    // Mode after reset
    localparam burstLenT ResetBurstLen = BurstLen1;
    localparam casLatT   ResetCasLat   = CasLat2;

endpackage

// ==== logic/sdramCmdDecode.sv ====
//********************
// Command decode, mode register and per-bank open row table
// READ or WRITE to a closed bank is dropped without a strobe
// ACTIVE to a bank that is already open is ignored
//********************
`timescale 1ns/1ps

module sdramCmdDecode (
    input  logic                     Clk,
    input  logic                     rst,
    input  logic                     csN,
    input  logic                     rasN,
    input  logic                     casN,
    input  logic                     weN,
    input  sdramGeomPkg::bankT       ba,
    input  sdramGeomPkg::addrT       addr,
    output logic                     wrStart,
    output sdramGeomPkg::bankT       wrBank,
    output sdramGeomPkg::rowT        wrRow,
    output sdramGeomPkg::colT        wrCol,
    output logic                     rdLoad,
    output logic                     rdLoadShort,
    output sdramGeomPkg::readAccessT rdAccess,
    output sdramCmdPkg::burstLenT    burstLen,
    output logic                     interleave
);
    import sdramGeomPkg::*;
    import sdramCmdPkg::*;

    cmdT                 cmd;
    casLatT              casLat;
    logic [NumBanks-1:0] bankOpen;
    rowT                 bankRow [NumBanks];
    logic                bankHit;

    //********************
    // Pin decode
    //********************
    always_comb begin
        if (csN) begin
            cmd = Nop;
        end else begin
            case ({rasN, casN, weN})
                3'b011:  cmd = Active;
                3'b101:  cmd = Read;
                3'b100:  cmd = Write;
                3'b010:  cmd = Precharge;
                3'b000:  cmd = LoadMode;
                default: cmd = Nop;
            endcase
        end
    end

    assign bankHit = bankOpen[ba];

    // Write strobe carries the stored row of the addressed bank
    assign wrStart = (cmd == Write) && bankHit;
    assign wrBank  = ba;
    assign wrRow   = bankRow[ba];
    assign wrCol   = addr[ColBits-1:0];

    // CL2 reads skip the first pipeline stage
    assign rdLoad      = (cmd == Read) && bankHit;
    assign rdLoadShort = rdLoad && (casLat == CasLat2);

    always_comb begin
        rdAccess.bank = ba;
        rdAccess.row  = bankRow[ba];
        rdAccess.col  = addr[ColBits-1:0];
    end

    //********************
    // Mode register
    //********************
    always_ff @(posedge Clk) begin
        if (rst) begin
            burstLen   <= ResetBurstLen;
            interleave <= 1'b0;
            casLat     <= ResetCasLat;
        end else if (cmd == LoadMode) begin
            // Full page and reserved codes fall back to BL1
            if (!addr[BurstLenLsb+2]) begin
                burstLen <= burstLenT'(addr[BurstLenLsb +: $bits(burstLenT)]);
            end else begin
                burstLen <= BurstLen1;
            end
            interleave <= addr[BurstTypeBit];
            casLat     <= (addr[CasLatLsb +: $bits(casLatT)] == CasLat3) ? CasLat3 : CasLat2;
        end
    end

    //********************
    // Open row table
    //********************
    always_ff @(posedge Clk) begin
        if (rst) begin
            bankOpen <= '0;
        end else if (cmd == Active) begin
            bankOpen[ba] <= 1'b1;
        end else if (cmd == Precharge) begin
            if (addr[AllBanksBit]) begin
                bankOpen <= '0;
            end else begin
                bankOpen[ba] <= 1'b0;
            end
        end
    end

    // Only the low row bits are kept
    always_ff @(posedge Clk) begin
        if ((cmd == Active) && !bankHit) begin
            bankRow[ba] <= addr[RowBits-1:0];
        end
    end

endmodule

// ==== logic/sdramReadPipe.sv ====
//********************
// CAS latency pipeline for read accesses
// Depth must be 2 or more; short loads enter stage 1
// A read can sit in every stage at once
//********************
`timescale 1ns/1ps

module sdramReadPipe #(
    parameter int Depth = 2
) (
    input  logic                     Clk,
    input  logic                     rst,
    input  logic                     rdLoad,
    input  logic                     rdLoadShort,
    input  sdramGeomPkg::readAccessT rdAccess,
    output logic                     rdStart,
    output sdramGeomPkg::readAccessT rdStartAccess
);
    import sdramGeomPkg::*;

    logic [Depth-1:0] stageValid;
    readAccessT       stageAcc [Depth];
    logic             longLoad;
    logic             shortLoad;

    assign longLoad  = rdLoad && !rdLoadShort;
    assign shortLoad = rdLoad && rdLoadShort;

    //********************
    // Valid bits
    //********************
    // A short load never meets a shifting read in stage 1,
    // since a mode change needs its own command cycle
    always_ff @(posedge Clk) begin
        if (rst) begin
            stageValid <= '0;
        end else begin
            stageValid[0] <= longLoad;
            for (int i = 1; i < Depth; i++) begin
                stageValid[i] <= stageValid[i-1] || ((i == 1) && shortLoad);
            end
        end
    end

    // Access fields shift alongside
    always_ff @(posedge Clk) begin
        stageAcc[0] <= rdAccess;
        for (int i = 1; i < Depth; i++) begin
            if ((i == 1) && shortLoad) begin
                stageAcc[i] <= rdAccess;
            end else begin
                stageAcc[i] <= stageAcc[i-1];
            end
        end
    end

    assign rdStart       = stageValid[Depth-1];
    assign rdStartAccess = stageAcc[Depth-1];

endmodule

// ==== logic/sdramDataPath.sv ====
//********************
// Bank arrays, burst sequencer and byte-masked data in and out
// Burst length and order are latched when a burst starts
// WRITE beats use the current dqm, read beats the dqm one edge older
// Write start wins over a read start at the same edge
//********************
`timescale 1ns/1ps

module sdramDataPath (
    input  logic                     Clk,
    input  logic                     rst,
    input  logic                     wrStart,
    input  sdramGeomPkg::bankT       wrBank,
    input  sdramGeomPkg::rowT        wrRow,
    input  sdramGeomPkg::colT        wrCol,
    input  logic                     rdStart,
    input  sdramGeomPkg::readAccessT rdStartAccess,
    input  sdramCmdPkg::burstLenT    burstLen,
    input  logic                     interleave,
    input  sdramGeomPkg::maskT       dqm,
    input  sdramGeomPkg::dataT       dqIn,
    output sdramGeomPkg::dataT       dqOut,
    output logic                     dqOutValid
);
    import sdramGeomPkg::*;

    dataT bankMem [NumBanks][2**(RowBits+ColBits)];
    maskT dqmQ;
    logic burstActive;
    logic burstWrite;
    logic ilvQ;
    colT  burstCnt;
    colT  startCol;
    colT  lenMask;
    colT  lenMaskNext;
    colT  beatCol;
    bankT curBank;
    rowT  curRow;
    bankT accBank;
    rowT  accRow;
    colT  accCol;
    dataT memWord;
    logic burstStart;
    logic memWrite;
    logic memRead;

    // Byte lanes with a mask bit of one keep oldWord
    function automatic dataT mergeBytes(dataT oldWord, dataT newWord, maskT mask);
        dataT merged;
        merged = oldWord;
        for (int i = 0; i < MaskBits; i++) begin
            if (!mask[i]) begin
                merged[i*(DataBits/MaskBits) +: DataBits/MaskBits] =
                    newWord[i*(DataBits/MaskBits) +: DataBits/MaskBits];
            end
        end
        return merged;
    endfunction

    //********************
    // Column sequencing
    //********************
    assign lenMaskNext = (colT'(1) << burstLen[1:0]) - colT'(1);

    // Sequential wraps inside the burst-aligned block
    always_comb begin
        if (ilvQ) begin
            beatCol = startCol ^ burstCnt;
        end else begin
            beatCol = (startCol & ~lenMask) | ((startCol + burstCnt) & lenMask);
        end
    end

    // One array port, shared by every access
    always_comb begin
        if (wrStart) begin
            accBank = wrBank;
            accRow  = wrRow;
            accCol  = wrCol;
        end else if (rdStart) begin
            accBank = rdStartAccess.bank;
            accRow  = rdStartAccess.row;
            accCol  = rdStartAccess.col;
        end else begin
            accBank = curBank;
            accRow  = curRow;
            accCol  = beatCol;
        end
    end

    assign burstStart = wrStart || rdStart;
    assign memWrite   = wrStart || (!rdStart && burstActive && burstWrite);
    assign memRead    = !wrStart && (rdStart || (burstActive && !burstWrite));
    assign memWord    = bankMem[accBank][{accRow, accCol}];

    //********************
    // Array and burst state
    //********************
    always_ff @(posedge Clk) begin
        if (memWrite) begin
            bankMem[accBank][{accRow, accCol}] <= mergeBytes(memWord, dqIn, dqm);
        end
    end

    // burstCnt is the index of the next beat
    always_ff @(posedge Clk) begin
        if (rst) begin
            burstActive <= 1'b0;
            burstWrite  <= 1'b0;
            burstCnt    <= '0;
        end else if (burstStart) begin
            burstActive <= (lenMaskNext != '0);
            burstWrite  <= wrStart;
            burstCnt    <= colT'(1);
        end else if (burstActive) begin
            burstActive <= (burstCnt != lenMask);
            burstCnt    <= burstCnt + colT'(1);
        end
    end

    always_ff @(posedge Clk) begin
        dqmQ <= dqm;
        if (burstStart) begin
            startCol <= accCol;
            curBank  <= accBank;
            curRow   <= accRow;
            lenMask  <= lenMaskNext;
            ilvQ     <= interleave;
        end
    end

    //********************
    // Read output
    //********************
    always_ff @(posedge Clk) begin
        if (rst) begin
            dqOutValid <= 1'b0;
        end else begin
            dqOutValid <= memRead;
        end
    end

    // Masked lanes read as zero
    always_ff @(posedge Clk) begin
        if (memRead) begin
            dqOut <= mergeBytes('0, memWord, dqmQ);
        end
    end

endmodule

// ==== logic/sdramDevice.sv ====
//********************
// Four-bank SDR SDRAM model, clocked RTL
// DQ is split into dqIn, dqOut and dqOutValid
// No refresh, no auto-precharge, no timing checks
//********************
`timescale 1ns/1ps

module sdramDevice (
    input  logic               Clk,
    input  logic               rst,
    input  logic               csN,
    input  logic               rasN,
    input  logic               casN,
    input  logic               weN,
    input  sdramGeomPkg::bankT ba,
    input  sdramGeomPkg::addrT addr,
    input  sdramGeomPkg::maskT dqm,
    input  sdramGeomPkg::dataT dqIn,
    output sdramGeomPkg::dataT dqOut,
    output logic               dqOutValid
);
    import sdramGeomPkg::*;
    import sdramCmdPkg::*;

    logic       wrStart;
    bankT       wrBank;
    rowT        wrRow;
    colT        wrCol;
    logic       rdLoad;
    logic       rdLoadShort;
    readAccessT rdAccess;
    logic       rdStart;
    readAccessT rdStartAccess;
    burstLenT   burstLen;
    logic       interleave;

    sdramCmdDecode cmdDecode (
        .Clk         (Clk),
        .rst         (rst),
        .csN         (csN),
        .rasN        (rasN),
        .casN        (casN),
        .weN         (weN),
        .ba          (ba),
        .addr        (addr),
        .wrStart     (wrStart),
        .wrBank      (wrBank),
        .wrRow       (wrRow),
        .wrCol       (wrCol),
        .rdLoad      (rdLoad),
        .rdLoadShort (rdLoadShort),
        .rdAccess    (rdAccess),
        .burstLen    (burstLen),
        .interleave  (interleave)
    );

    // Two stages cover CL2 and CL3
    sdramReadPipe #(
        .Depth (2)
    ) readPipe (
        .Clk           (Clk),
        .rst           (rst),
        .rdLoad        (rdLoad),
        .rdLoadShort   (rdLoadShort),
        .rdAccess      (rdAccess),
        .rdStart       (rdStart),
        .rdStartAccess (rdStartAccess)
    );

    sdramDataPath dataPath (
        .Clk           (Clk),
        .rst           (rst),
        .wrStart       (wrStart),
        .wrBank        (wrBank),
        .wrRow         (wrRow),
        .wrCol         (wrCol),
        .rdStart       (rdStart),
        .rdStartAccess (rdStartAccess),
        .burstLen      (burstLen),
        .interleave    (interleave),
        .dqm           (dqm),
        .dqIn          (dqIn),
        .dqOut         (dqOut),
        .dqOutValid    (dqOutValid)
    );

endmodule

// ==== verification/sdramDevice_asserts.sv ====
//********************
// Concurrent checks on the SDRAM data path, bound into sdramDataPath
// failCount holds the number of failed assertions
//********************
`timescale 1ns/1ps

module sdramDevice_asserts (
    input logic                  Clk,
    input logic                  rst,
    input logic                  wrStart,
    input logic                  rdStart,
    input sdramCmdPkg::burstLenT burstLen,
    input logic                  dqOutValid
);
    int         failCount = 0;
    logic [3:0] beats;
    logic [3:0] burstBeats;

    // Output beats seen since the latest read start
    always_ff @(posedge Clk) begin
        if (rst) begin
            beats      <= '0;
            burstBeats <= 4'd1;
        end else if (rdStart && !wrStart) begin
            beats      <= '0;
            burstBeats <= 4'd1 << burstLen[1:0];
        end else if (dqOutValid) begin
            beats <= beats + 4'd1;
        end
    end

    // Second cycle depends on burst and pipeline state coming out of reset
    afterReset: assert property (@(posedge Clk) $fell(rst) |-> !dqOutValid ##1 !dqOutValid)
        else begin
            failCount++;
            $error("dqOutValid is high in the first cycles after reset");
        end

    burstBound: assert property (@(posedge Clk) disable iff (rst)
        dqOutValid |-> (beats < burstBeats))
        else begin
            failCount++;
            $error("read burst gave more beats than its burst length");
        end

    // Output stays off after a write start unless a new read starts
    writeStops: assert property (@(posedge Clk) disable iff (rst)
        wrStart |=> !dqOutValid ##1 (!dqOutValid || $past(rdStart)))
        else begin
            failCount++;
            $error("dqOutValid went high after a write start without a new read");
        end

endmodule

bind sdramDataPath sdramDevice_asserts dataPathChecks (
    .Clk        (Clk),
    .rst        (rst),
    .wrStart    (wrStart),
    .rdStart    (rdStart),
    .burstLen   (burstLen),
    .dqOutValid (dqOutValid)
);

// ==== verification/sdramDevice_tb.sv ====
//********************
// Random command testbench for the SDRAM model
// Only rows 0..3 and columns 0..31 are used, all preloaded first
// Mode changes happen only while the device is idle
//********************
`timescale 1ns/1ps

module sdramDevice_tb;
    import sdramGeomPkg::*;
    import sdramCmdPkg::*;

    localparam int ClkPeriodNs   = 10;
    localparam int NumOps        = 60;
    localparam int UsedRows      = 4;
    localparam int UsedCols      = 32;
    localparam int PreloadBursts = NumBanks * UsedRows * UsedCols / 8;
    localparam int MaxSeqLen     = 40;
    localparam int WatchdogNs    = (NumOps + PreloadBursts) * MaxSeqLen * ClkPeriodNs;

    logic Clk;
    logic rst;
    logic csN;
    logic rasN;
    logic casN;
    logic weN;
    bankT ba;
    addrT addr;
    maskT dqm;
    dataT dqIn;
    dataT dqOut;
    logic dqOutValid;

    // Reference model state
    dataT                modelMem [NumBanks][2**(RowBits+ColBits)];
    logic [NumBanks-1:0] openM = '0;
    rowT                 rowM [NumBanks];
    int                  blM = 1;
    logic                ilvM = 1'b0;
    int                  clM = 2;
    logic                wrActive = 1'b0;
    int                  wrBeat;
    bankT                wrBankM;
    rowT                 wrRowM;
    colT                 wrColM;
    int                  wrBl;
    logic                wrIlv;
    dataT                expWord [int];
    maskT                dqmHist [int];
    int                  lastDue = -1;
    int                  edgeNow = 0;
    int                  cmdEdge;
    int                  errors = 0;
    int                  totalFails;
    logic                checking = 1'b0;
    logic [31:0]         seed = 32'h5fab_41aa;

    sdramDevice uut (
        .Clk        (Clk),
        .rst        (rst),
        .csN        (csN),
        .rasN       (rasN),
        .casN       (casN),
        .weN        (weN),
        .ba         (ba),
        .addr       (addr),
        .dqm        (dqm),
        .dqIn       (dqIn),
        .dqOut      (dqOut),
        .dqOutValid (dqOutValid)
    );

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriodNs / 2) Clk = ~Clk;
    end

    //********************
    // Random numbers and data helpers
    //********************
    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 16);
    endfunction

    function automatic int randBelow(int n);
        logic [31:0] r;
        r = nextRand();
        return int'(r[31:8]) % n;
    endfunction

    // Mostly unmasked, a quarter of the cycles get a random mask
    function automatic maskT randMask();
        logic [31:0] r;
        r = nextRand();
        if (r[9:8] == 2'b00) begin
            return maskT'(r[3:0]);
        end
        return '0;
    endfunction

    // Ones in every byte lane whose mask bit is clear
    function automatic dataT laneBits(maskT m);
        dataT bits;
        for (int i = 0; i < MaskBits; i++) begin
            bits[i*8 +: 8] = {8{~m[i]}};
        end
        return bits;
    endfunction

    // Sequential order wraps inside the aligned block, interleaved uses xor
    function automatic colT beatCol(colT start, int idx, int bl, logic ilv);
        int base;
        if (ilv) begin
            return start ^ colT'(idx);
        end
        base = int'(start) - (int'(start) % bl);
        return colT'(base + ((int'(start) % bl + idx) % bl));
    endfunction

    function automatic addrT randomRowAddr();
        return addrT'((nextRand() & 32'h7c0) | randBelow(UsedRows));
    endfunction

    //********************
    // Checks
    //********************
    task automatic checkValid(logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: dqOutValid is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic checkData(dataT got, dataT exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: dqOut is %h, expected %h", $time, got, exp);
        end
    endtask

    // Read beats use the dqm sampled two edges before
    always @(posedge Clk) begin
        edgeNow <= edgeNow + 1;
        dqmHist[edgeNow] = dqm;
        if (checking) begin
            if (expWord.exists(edgeNow)) begin
                checkValid(dqOutValid, 1'b1);
                checkData(dqOut, expWord[edgeNow] & laneBits(dqmHist[edgeNow-2]));
            end else begin
                checkValid(dqOutValid, 1'b0);
            end
        end
    end

    //********************
    // Stimulus and model update
    //********************
    task automatic cutFrom(int first);
        for (int e = first; e < first + 16; e++) begin
            if (expWord.exists(e)) begin
                expWord.delete(e);
            end
        end
    endtask

    task automatic issueCmd(cmdT c, bankT b, addrT a, dataT d, maskT m);
        int  f;
        colT col;
        @(posedge Clk);
        csN <= (c == Nop);
        case (c)
            Active:    {rasN, casN, weN} <= 3'b011;
            Read:      {rasN, casN, weN} <= 3'b101;
            Write:     {rasN, casN, weN} <= 3'b100;
            Precharge: {rasN, casN, weN} <= 3'b010;
            LoadMode:  {rasN, casN, weN} <= 3'b000;
            default:   {rasN, casN, weN} <= 3'b111;
        endcase
        ba   <= b;
        addr <= a;
        dqIn <= d;
        dqm  <= m;
        cmdEdge = edgeNow + 1;
        case (c)
            Active: begin
                if (!openM[b]) begin
                    openM[b] = 1'b1;
                    rowM[b]  = a[RowBits-1:0];
                end
            end
            Precharge: begin
                if (a[AllBanksBit]) begin
                    openM = '0;
                end else begin
                    openM[b] = 1'b0;
                end
            end
            LoadMode: begin
                blM  = 1 << a[BurstLenLsb +: 2];
                ilvM = a[BurstTypeBit];
                clM  = int'(a[CasLatLsb +: 3]);
            end
            Write: begin
                if (openM[b]) begin
                    cutFrom(cmdEdge + 1);
                    wrActive = 1'b1;
                    wrBeat   = 0;
                    wrBankM  = b;
                    wrRowM   = rowM[b];
                    wrColM   = a[ColBits-1:0];
                    wrBl     = blM;
                    wrIlv    = ilvM;
                end
            end
            Read: begin
                if (openM[b]) begin
                    f = cmdEdge + clM;
                    cutFrom(f);
                    for (int i = 0; i < blM; i++) begin
                        col = beatCol(a[ColBits-1:0], i, blM, ilvM);
                        expWord[f+i] = modelMem[b][{rowM[b], col}];
                    end
                    lastDue = f + blM - 1;
                end
            end
            default: ;
        endcase
        // Write beats take the dqm of their own edge
        if (wrActive) begin
            col = beatCol(wrColM, wrBeat, wrBl, wrIlv);
            modelMem[wrBankM][{wrRowM, col}] =
                (modelMem[wrBankM][{wrRowM, col}] & ~laneBits(m)) | (d & laneBits(m));
            wrBeat++;
            if (wrBeat == wrBl) begin
                wrActive = 1'b0;
            end
        end
    endtask

    task automatic idle(int n);
        repeat (n) begin
            issueCmd(Nop, bankT'(randBelow(NumBanks)), addrT'(nextRand()), nextRand(), randMask());
        end
    endtask

    task automatic drain();
        while (wrActive || edgeNow <= lastDue) begin
            idle(1);
        end
    endtask

    task automatic setMode(int blCode, logic ilv, int cl);
        addrT a;
        a = '0;
        a[BurstLenLsb +: 3] = 3'(blCode);
        a[BurstTypeBit]     = ilv;
        a[CasLatLsb +: 3]   = 3'(cl);
        issueCmd(LoadMode, '0, a, nextRand(), '0);
    endtask

    task automatic openAllBanks();
        for (int i = 0; i < NumBanks; i++) begin
            if (!openM[i]) begin
                issueCmd(Active, bankT'(i), randomRowAddr(), nextRand(), '0);
            end
        end
    endtask

    //********************
    // Test sequences
    //********************
    task automatic preload();
        colT c;
        setMode(3, 1'b0, 2);
        for (int r = 0; r < UsedRows; r++) begin
            for (int b = 0; b < NumBanks; b++) begin
                issueCmd(Active, bankT'(b), addrT'(r), '0, '0);
            end
            for (int b = 0; b < NumBanks; b++) begin
                for (int blk = 0; blk < UsedCols; blk += 8) begin
                    for (int i = 0; i < 8; i++) begin
                        c = colT'(blk + i);
                        issueCmd((i == 0) ? Write : Nop, bankT'(b), addrT'(c),
                            {2'b0, bankT'(b), rowT'(r), c} * 32'h0001_0003 ^ 32'h3c5a_9600, '0);
                    end
                end
            end
            issueCmd(Precharge, '0, addrT'(1) << AllBanksBit, '0, '0);
        end
    endtask

    task automatic writeThenRead();
        bankT b;
        colT  c;
        b = bankT'(randBelow(NumBanks));
        c = colT'(randBelow(UsedCols));
        setMode(randBelow(4), randBelow(2), 2 + randBelow(2));
        issueCmd(Precharge, b, '0, nextRand(), '0);
        issueCmd(Active, b, randomRowAddr(), nextRand(), '0);
        issueCmd(Write, b, addrT'(c), nextRand(), randMask());
        idle(blM - 1 + randBelow(3));
        issueCmd(Read, b, addrT'(c), nextRand(), randMask());
        drain();
    endtask

    // Back to back reads, each cutting the one before
    task automatic readStream();
        bankT b;
        int   n;
        setMode(randBelow(4), randBelow(2), 2 + randBelow(2));
        openAllBanks();
        b = bankT'(randBelow(NumBanks));
        n = 2 + randBelow(3);
        for (int i = 0; i < n; i++) begin
            issueCmd(Read, b, addrT'(randBelow(UsedCols)), nextRand(), randMask());
            b = bankT'(int'(b) + 1 + randBelow(NumBanks - 1));
        end
        drain();
    endtask

    // Write lands no earlier than the edge where the read burst starts
    task automatic readThenWrite();
        setMode(randBelow(4), randBelow(2), 2 + randBelow(2));
        openAllBanks();
        issueCmd(Read, bankT'(randBelow(NumBanks)), addrT'(randBelow(UsedCols)),
            nextRand(), randMask());
        idle(clM - 2 + randBelow(blM + 2));
        issueCmd(Write, bankT'(randBelow(NumBanks)), addrT'(randBelow(UsedCols)),
            nextRand(), randMask());
        drain();
    endtask

    task automatic closedBankAccess();
        bankT b;
        colT  c;
        b = bankT'(randBelow(NumBanks));
        c = colT'(randBelow(UsedCols));
        if (randBelow(2) == 0) begin
            issueCmd(Precharge, bankT'(randBelow(NumBanks)), addrT'(1) << AllBanksBit,
                nextRand(), '0);
        end else begin
            issueCmd(Precharge, b, '0, nextRand(), '0);
        end
        issueCmd(Read, b, addrT'(c), nextRand(), randMask());
        issueCmd(Write, b, addrT'(c), nextRand(), '0);
        idle(4);
        // Same row again, the old data must still be there
        issueCmd(Active, b, addrT'(rowM[b]), nextRand(), '0);
        issueCmd(Read, b, addrT'(c), nextRand(), randMask());
        drain();
    endtask

    //********************
    // Main sequence and watchdog
    //********************
    initial begin
        rst  = 1'b1;
        csN  = 1'b1;
        rasN = 1'b1;
        casN = 1'b1;
        weN  = 1'b1;
        ba   = '0;
        addr = '0;
        dqm  = '0;
        dqIn = '0;
        repeat (5) @(posedge Clk);
        rst      <= 1'b0;
        checking <= 1'b1;
        preload();
        for (int op = 0; op < NumOps; op++) begin
            case (randBelow(4))
                0:       writeThenRead();
                1:       readStream();
                2:       readThenWrite();
                default: closedBankAccess();
            endcase
        end
        drain();
        idle(3);
        totalFails = errors + uut.dataPath.dataPathChecks.failCount;
        $display("Run finished with %0d check errors and %0d assertion failures",
            errors, uut.dataPath.dataPathChecks.failCount);
        if (totalFails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WatchdogNs);
        $display("Timeout: the run did not finish within %0d ns", WatchdogNs);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== all.f ====
logic/sdramGeomPkg.sv
logic/sdramCmdPkg.sv
logic/sdramCmdDecode.sv
logic/sdramReadPipe.sv
logic/sdramDataPath.sv
logic/sdramDevice.sv
verification/sdramDevice_asserts.sv
verification/sdramDevice_tb.sv
